//--- Bender.yml
package:
  name: dds_modulation

sources:
  - include_dirs:
      - common
      - dds
    files:
      - common/dds_pkg.sv
      - common/wave_if.sv
      - dds/waveform_gen.sv
      - modulation/modulation_stage.sv
      - verilog/key_state_tracker.sv
      - verilog/lfsr_bitstream.sv
      - verilog/dds_modulation_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/dds_checker.sv
      - verification/tb_dds_modulation.sv

//--- common/dds_defs.svh
`ifndef DDS_DEFS_SVH
`define DDS_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////////////////////

`define DDS_SAMPLE_WIDTH   12              // signed sample, all four waveforms
`define DDS_PHASE_WIDTH    32              // phase accumulator

// fixed tuning word for every mode but fsk
// 515 * 25e6 / 2^32 gives roughly 3 Hz
`define DDS_DEFAULT_INC    32'd515

////////////////////////////////////////////////////////////////////////////
// bitstream source
////////////////////////////////////////////////////////////////////////////

`define LFSR_WIDTH         5
`define LFSR_SEED          1               // loaded at reset, never all zero
`define BIT_PERIOD_CYCLES  25000000        // one data bit per second

// quarter-wave table depth, 2^5 entries
`define SINE_TABLE_BITS    5

`endif

//--- common/dds_pkg.sv
`default_nettype none
`include "dds_defs.svh"

package dds_pkg;

   typedef logic signed [`DDS_SAMPLE_WIDTH-1:0] sample_t;
   typedef logic        [`DDS_PHASE_WIDTH-1:0]  phase_t;
   typedef logic        [`LFSR_WIDTH-1:0]       lfsr_t;

   // one byte per event, break code is the make code with bit 7 set
   typedef enum logic [7:0] {
      MAKE_1     = 8'h16, BREAK_1     = 8'h96,
      MAKE_2     = 8'h1e, BREAK_2     = 8'h9e,
      MAKE_3     = 8'h26, BREAK_3     = 8'ha6,
      MAKE_4     = 8'h25, BREAK_4     = 8'ha5,
      MAKE_5     = 8'h2e, BREAK_5     = 8'hae,
      MAKE_6     = 8'h36, BREAK_6     = 8'hb6,
      MAKE_7     = 8'h3d, BREAK_7     = 8'hbd,
      MAKE_8     = 8'h3e, BREAK_8     = 8'hbe,
      MAKE_F1    = 8'h05, BREAK_F1    = 8'h85,
      MAKE_F2    = 8'h06, BREAK_F2    = 8'h86,
      MAKE_N     = 8'h31, BREAK_N     = 8'hb1,
      MAKE_M     = 8'h3a, BREAK_M     = 8'hba,
      MAKE_SPACE = 8'h29, BREAK_SPACE = 8'ha9,
      MAKE_LEFT  = 8'h6b, BREAK_LEFT  = 8'heb,
      MAKE_RIGHT = 8'h74, BREAK_RIGHT = 8'hf4,
      MAKE_UP    = 8'h75, BREAK_UP    = 8'hf5,
      MAKE_DOWN  = 8'h72, BREAK_DOWN  = 8'hf2
   } key_event_t;

   // msb first: digits, function keys, letters, space, arrows
   typedef struct packed {
      logic key_1, key_2, key_3, key_4, key_5, key_6, key_7, key_8;
      logic f1, f2;
      logic n, m;
      logic space;
      logic left, right, up, down;
   } held_keys_t;

   typedef enum logic [1:0] {SINE = 2'd0, COSINE = 2'd1, SAW = 2'd2, SQUARE = 2'd3} waveform_t;

   typedef enum logic [1:0] {ASK = 2'd0, FSK = 2'd1, BPSK = 2'd2, OOK = 2'd3} modulation_t;

endpackage

`default_nettype wire

//--- common/wave_if.sv
`timescale 1ns/100ps
`default_nettype none

// the four generator outputs, updated together every clock
interface wave_if;
   import dds_pkg::*;

   sample_t sin;
   sample_t cos;
   sample_t saw;
   sample_t squ;

   modport source
   (
      output sin, cos, saw, squ
   );

   modport sink
   (
      input sin, cos, saw, squ
   );
endinterface

`default_nettype wire

//--- dds/sine_quarter_table.svh
`ifndef SINE_QUARTER_TABLE_SVH
`define SINE_QUARTER_TABLE_SVH

// round(2047 * sin((i + 0.5) * pi / 64)), first quarter wave
// the half-step offset makes the mirrored quadrants exact
localparam logic [`DDS_SAMPLE_WIDTH-2:0] sine_quarter_table [0:(1<<`SINE_TABLE_BITS)-1] = '{
   11'd50,
   11'd151,
   11'd251,
   11'd350,
   11'd449,
   11'd546,
   11'd642,
   11'd737,
   11'd830,
   11'd920,
   11'd1009,
   11'd1095,
   11'd1179,
   11'd1259,
   11'd1337,
   11'd1411,
   11'd1483,
   11'd1550,
   11'd1614,
   11'd1674,
   11'd1729,
   11'd1781,
   11'd1828,
   11'd1871,
   11'd1910,
   11'd1944,
   11'd1973,
   11'd1997,
   11'd2017,
   11'd2032,
   11'd2041,
   11'd2046
};

`endif

//--- dds/waveform_gen.sv
`timescale 1ns/100ps
`default_nettype none
`include "dds_defs.svh"

module waveform_gen
(
   input  wire              CLK_25MHZ,
   input  wire              reset_from_key,
   input  dds_pkg::phase_t  phase_inc,
   wave_if.source           wave
);
   import dds_pkg::*;

   `include "sine_quarter_table.svh"

   localparam int      tbl_bits     = `SINE_TABLE_BITS;
   localparam phase_t  quarter_turn = phase_t'(1) << (`DDS_PHASE_WIDTH - 2);
   localparam sample_t full_pos     = {1'b0, {(`DDS_SAMPLE_WIDTH-1){1'b1}}};   // +2047
   localparam sample_t full_neg     = {1'b1, {(`DDS_SAMPLE_WIDTH-1){1'b0}}};   // -2048

   phase_t phase_q;
   phase_t cos_phase;

   // idx is quadrant plus table address
   function automatic sample_t sine_lookup(input logic [tbl_bits+1:0] idx);
      logic [tbl_bits-1:0]          addr;
      logic [`DDS_SAMPLE_WIDTH-2:0] mag;
      addr = idx[tbl_bits] ? ~idx[tbl_bits-1:0] : idx[tbl_bits-1:0];   // falling quadrants
      mag  = sine_quarter_table[addr];
      if (idx[tbl_bits+1])
         return -sample_t'({1'b0, mag});    // second half-wave
      else
         return sample_t'({1'b0, mag});
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // phase accumulator
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         phase_q <= '0;
      else
         phase_q <= phase_q + phase_inc;   // wraps once per output period
   end

   assign cos_phase = phase_q + quarter_turn;

   ////////////////////////////////////////////////////////////////////////////
   // shaping, one cycle behind the phase
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         wave.sin <= '0;
         wave.cos <= '0;
         wave.saw <= '0;
         wave.squ <= '0;
      end
      else
      begin
         wave.sin <= sine_lookup(phase_q[`DDS_PHASE_WIDTH-1 -: tbl_bits+2]);
         wave.cos <= sine_lookup(cos_phase[`DDS_PHASE_WIDTH-1 -: tbl_bits+2]);
         wave.saw <= sample_t'(phase_q[`DDS_PHASE_WIDTH-1 -: `DDS_SAMPLE_WIDTH]);
         wave.squ <= phase_q[`DDS_PHASE_WIDTH-1] ? full_neg : full_pos;
      end
   end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+common
+incdir+dds
common/dds_pkg.sv
common/wave_if.sv
dds/waveform_gen.sv
modulation/modulation_stage.sv
verilog/key_state_tracker.sv
verilog/lfsr_bitstream.sv
verilog/dds_modulation_top.sv
verification/dds_checker.sv
verification/tb_dds_modulation.sv

//--- modulation/modulation_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "dds_defs.svh"

module modulation_stage
(
   input  wire                   CLK_25MHZ,
   input  wire                   reset_from_key,
   input  dds_pkg::modulation_t  modulation_select,
   input  dds_pkg::waveform_t    signal_select,
   input  dds_pkg::phase_t       fsk_increment,
   input  wire                   data_bit,
   wave_if.sink                  wave,
   output dds_pkg::phase_t       phase_inc,
   output logic                  bit_out,
   output dds_pkg::sample_t      modulated,
   output dds_pkg::sample_t      selected
);
   import dds_pkg::*;

   sample_t modulated_d;
   sample_t selected_d;

   // only fsk retunes the generator
   assign phase_inc = (modulation_select == FSK) ? fsk_increment : `DDS_DEFAULT_INC;

   always_comb
   begin
      case (modulation_select)
         ASK:     modulated_d = data_bit ? wave.sin : '0;
         FSK:     modulated_d = wave.sin;                       // keying is in the tuning word
         BPSK:    modulated_d = data_bit ? wave.sin : ~wave.sin; // 180 degree flip
         default: modulated_d = {data_bit, {(`DDS_SAMPLE_WIDTH-1){1'b0}}};
      endcase
   end

   always_comb
   begin
      case (signal_select)
         SINE:    selected_d = wave.sin;
         COSINE:  selected_d = wave.cos;
         SAW:     selected_d = wave.saw;
         default: selected_d = wave.squ;
      endcase
   end

   // bit registered beside the samples it keyed
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         bit_out   <= 1'b0;
         modulated <= '0;
         selected  <= '0;
      end
      else
      begin
         bit_out   <= data_bit;
         modulated <= modulated_d;
         selected  <= selected_d;
      end
   end

endmodule

`default_nettype wire

//--- verification/dds_checker.sv
`timescale 1ns/100ps
`default_nettype none

module dds_checker
(
   input wire                   CLK_25MHZ,
   input wire                   reset_from_key,
   input wire                   kbd_event_ready,
   input dds_pkg::modulation_t  modulation_select,
   input dds_pkg::held_keys_t   held_keys,
   input wire                   lfsr_bit,
   input dds_pkg::sample_t      modulated_out,
   input dds_pkg::sample_t      selected_out
);
   import dds_pkg::*;

   int failures = 0;

   // held state only moves on an accepted strobe
   held_needs_event: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      (held_keys != $past(held_keys)) |-> $past(kbd_event_ready))
   else
   begin
      $error("held_keys changed without an event strobe");
      failures++;
   end

   ook_low_bits_zero: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      ($past(modulation_select) == OOK) |-> (modulated_out[$bits(sample_t)-2:0] == '0))
   else
   begin
      $error("ook output has nonzero low bits");
      failures++;
   end

   zero_after_reset: assert property (@(posedge CLK_25MHZ)
      $past(reset_from_key) |-> (modulated_out == '0) && (selected_out == '0)
                                && (held_keys == '0) && !lfsr_bit)
   else
   begin
      $error("outputs not cleared after reset");
      failures++;
   end

endmodule

bind dds_modulation_top dds_checker u_checker
(
   .CLK_25MHZ         (CLK_25MHZ),
   .reset_from_key    (reset_from_key),
   .kbd_event_ready   (kbd_event_ready),
   .modulation_select (modulation_select),
   .held_keys         (held_keys),
   .lfsr_bit          (lfsr_bit),
   .modulated_out     (modulated_out),
   .selected_out      (selected_out)
);

`default_nettype wire

//--- verification/dds_stim.txt
# E <ready> <event code hex> <expected held_keys hex one cycle after the strobe>
# S <signal_select> <modulation_select> <fsk_increment hex> <cycles observed>
E 1 16 10000
E 1 1e 18000
E 1 3a 18020
E 0 75 18020
E 1 75 18022
E 1 1c 18022
E 1 96 08022
E 1 05 08122
E 1 29 08132
E 1 3e 08332
E 1 72 08333
E 1 6b 0833b
E 1 e0 0833b
E 1 9e 0033b
E 1 ba 0031b
E 1 f5 00319
E 1 85 00219
E 1 a9 00209
E 1 26 04209
E 1 25 06209
E 1 2e 07209
E 1 36 07a09
E 1 3d 07e09
E 1 06 07e89
E 1 31 07ec9
E 1 74 07ecd
S 0 0 00000000 120
S 0 2 00000000 120
S 0 3 00000000 120
S 2 1 01000000 48
S 3 1 10000000 64
S 1 1 08000000 96

//--- verification/tb_dds_modulation.sv
`timescale 1ns/100ps
`default_nettype none
`include "dds_defs.svh"

module tb_dds_modulation;
   import dds_pkg::*;

   localparam int bit_period    = 40;
   localparam int settle_cycles = 8;
   localparam int lfsr_periods  = 62;

   logic        CLK_25MHZ = 1'b0;
   logic        reset_from_key;
   logic        kbd_event_ready;
   logic [7:0]  kbd_event_type;
   waveform_t   signal_select;
   modulation_t modulation_select;
   phase_t      fsk_increment;
   held_keys_t  held_keys;
   logic        lfsr_bit;
   sample_t     modulated_out;
   sample_t     selected_out;

   integer seed = 32'had28;
   int     since_reset;          // edges since the last one that saw reset
   int     limit_cycles = 0;

   // stim file contents
   int        ev_ready[$];
   int        ev_code[$];
   int        ev_held[$];
   int        st_signal[$];
   int        st_mode[$];
   bit [31:0] st_inc[$];
   int        st_cycles[$];

   dds_modulation_top #(.bit_period_cycles(bit_period)) dut0
   (
      .CLK_25MHZ         (CLK_25MHZ),
      .reset_from_key    (reset_from_key),
      .kbd_event_ready   (kbd_event_ready),
      .kbd_event_type    (kbd_event_type),
      .signal_select     (signal_select),
      .modulation_select (modulation_select),
      .fsk_increment     (fsk_increment),
      .held_keys         (held_keys),
      .lfsr_bit          (lfsr_bit),
      .modulated_out     (modulated_out),
      .selected_out      (selected_out)
   );

   always #20 CLK_25MHZ = ~CLK_25MHZ;

   always @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         since_reset <= 0;
      else
         since_reset <= since_reset + 1;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_equal(input string name, input int expected, input int actual);
      if (expected != actual)
         fail_run($sformatf("[ERROR] %s: expected %0d (0x%0h) actual %0d (0x%0h)",
                            name, expected, expected, actual, actual));
   endtask

   task automatic load_stim();
      int    fd;
      int    n;
      int    a, b, c, d;
      int    total;
      string line;
      fd = $fopen("verification/dds_stim.txt", "r");
      if (fd == 0)
         fail_run("could not open the stimulus file verification/dds_stim.txt");
      total = 2000 + 10 + (lfsr_periods + 1) * bit_period;
      while ($fgets(line, fd) != 0)
      begin
         if (line.len() < 2 || line[0] == "#")
            continue;
         if (line[0] == "E")
         begin
            n = $sscanf(line, "E %d %h %h", a, b, c);
            if (n != 3)
               fail_run("an event line in the stimulus file is incomplete");
            ev_ready.push_back(a);
            ev_code.push_back(b);
            ev_held.push_back(c);
            total += 6;                  // worst case gap plus strobe
         end
         else if (line[0] == "S")
         begin
            n = $sscanf(line, "S %d %d %h %d", a, b, c, d);
            if (n != 4)
               fail_run("a settings line in the stimulus file is incomplete");
            st_signal.push_back(a);
            st_mode.push_back(b);
            st_inc.push_back(c);
            st_cycles.push_back(d);
            total += d + settle_cycles + 2;
         end
         else
            fail_run("the stimulus file holds a line that is neither an event nor a setting");
      end
      $fclose(fd);
      limit_cycles = total;
   endtask

   task automatic apply_event(input int ready, input int code, input int expected);
      int gap;
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(posedge CLK_25MHZ);
      @(posedge CLK_25MHZ);
      kbd_event_ready <= ready[0];
      kbd_event_type  <= code[7:0];
      @(posedge CLK_25MHZ);
      kbd_event_ready <= 1'b0;
      @(negedge CLK_25MHZ);                 // held vector one cycle after the strobe
      check_equal($sformatf("key event %02h", code), expected, int'(held_keys));
   endtask

   // new msb is bit 0 xor bit 2 as the register shifts toward bit 0
   function automatic logic [`LFSR_WIDTH-1:0] lfsr_after(input int steps);
      logic [`LFSR_WIDTH-1:0] s;
      int                     i;
      s = `LFSR_SEED;
      for (i = 0; i < steps; i++)
         s = {s[0] ^ s[2], s[`LFSR_WIDTH-1:1]};
      return s;
   endfunction

   task automatic check_bitstream();
      int                     seen[$];
      int                     period;
      int                     i;
      logic [`LFSR_WIDTH-1:0] model;
      while (seen.size() < lfsr_periods)
      begin
         @(negedge CLK_25MHZ);
         if (since_reset % bit_period == bit_period / 2)   // mid bit
         begin
            period = since_reset / bit_period;
            model  = lfsr_after(period);
            check_equal("lfsr bit", model[0], lfsr_bit);
            seen.push_back(lfsr_bit);
         end
      end
      for (i = 31; i < lfsr_periods; i++)
         check_equal("lfsr repeats after 31 bits", seen[i - 31], seen[i]);
   endtask

   task automatic run_setting(input int sig, input int mode, input bit [31:0] inc,
                              input int cycles);
      int    sel[$];
      int    modv[$];
      int    bits[$];
      int    i, q, half, run, expected;
      bit    seen_edge;
      string name;
      @(posedge CLK_25MHZ);
      signal_select     <= waveform_t'(sig);
      modulation_select <= modulation_t'(mode);
      fsk_increment     <= inc;
      repeat (settle_cycles) @(posedge CLK_25MHZ);
      repeat (cycles)
      begin
         @(negedge CLK_25MHZ);
         sel.push_back(int'(selected_out));
         modv.push_back(int'(modulated_out));
         bits.push_back(int'(lfsr_bit));
      end

      ////////////////////////////////////////////////////////////////////////////
      // keying modes apply the rule to the same-cycle sine and bit
      ////////////////////////////////////////////////////////////////////////////
      if (mode != FSK)
      begin
         if (sig != SINE)
            fail_run("a keying settings line must select the sine waveform");
         name = (mode == ASK) ? "ask keying" : (mode == BPSK) ? "bpsk keying" : "ook keying";
         for (i = 0; i < cycles; i++)
         begin
            if (mode == ASK)
               expected = bits[i] ? sel[i] : 0;
            else if (mode == BPSK)
               expected = bits[i] ? sel[i] : ~sel[i];
            else
               expected = bits[i] ? -2048 : 0;   // bit in the msb only
            check_equal(name, expected, modv[i]);
         end
      end
      else if (sig == SAW)
      begin
         for (i = 1; i < cycles; i++)
            check_equal("saw step", int'(inc[31:20]), (sel[i] - sel[i - 1]) & 4095);
      end
      else if (sig == SQUARE)
      begin
         half      = 32'h8000_0000 / inc;
         run       = 1;
         seen_edge = 1'b0;
         for (i = 0; i < cycles; i++)
         begin
            expected = (sel[i] < 0) ? -2048 : 2047;
            check_equal("square level", expected, sel[i]);
            if (i > 0 && sel[i] != sel[i - 1])
            begin
               if (seen_edge)
                  check_equal("square half period", half, run);
               seen_edge = 1'b1;
               run       = 1;
            end
            else if (i > 0)
               run++;
            if (run > half)
               check_equal("square half period", half, run);
         end
      end
      else if (sig == COSINE)
      begin
         q = 32'h4000_0000 / inc;               // cycles per quarter turn
         for (i = 0; i + 2 * q < cycles; i++)
         begin
            check_equal("cosine leads sine", sel[i], modv[i + q]);
            if (modv[i] != 0)
               check_equal("sine half turn", -modv[i], modv[i + 2 * q]);
         end
      end
      else
      begin
         for (i = 0; i < cycles; i++)
            check_equal("fsk sine", sel[i], modv[i]);
      end
   endtask

   initial
   begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge CLK_25MHZ);
      fail_run($sformatf("timeout, the tests did not finish within %0d cycles", limit_cycles));
   end

   // a bound assertion that fires ends the run at once
   always @(posedge CLK_25MHZ)
   begin
      if (dut0.u_checker.failures != 0)
         fail_run("an assertion in the bound checker failed");
   end

   initial
   begin
      int i;
      reset_from_key    = 1'b1;
      kbd_event_ready   = 1'b0;
      kbd_event_type    = 8'h00;
      signal_select     = SINE;
      modulation_select = ASK;
      fsk_increment     = '0;
      load_stim();

      repeat (5) @(posedge CLK_25MHZ);
      reset_from_key <= 1'b0;
      @(negedge CLK_25MHZ);
      check_equal("reset held_keys", 0, int'(held_keys));
      check_equal("reset modulated_out", 0, int'(modulated_out));
      check_equal("reset selected_out", 0, int'(selected_out));

      for (i = 0; i < ev_code.size(); i++)
         apply_event(ev_ready[i], ev_code[i], ev_held[i]);

      check_bitstream();

      for (i = 0; i < st_mode.size(); i++)
         run_setting(st_signal[i], st_mode[i], st_inc[i], st_cycles[i]);

      @(negedge CLK_25MHZ);
      if (dut0.u_checker.failures == 0)
      begin
         $display("Test passed");
         $finish;
      end
      else
      begin
         $display("%0d assertion failures in the bound checker", dut0.u_checker.failures);
         $display("Test failed");
         $fatal(1, "assertions failed");
      end
   end

endmodule

`default_nettype wire

//--- verilog/dds_modulation_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "dds_defs.svh"

module dds_modulation_top
#(
   parameter int bit_period_cycles = `BIT_PERIOD_CYCLES
)
(
   input  wire                      CLK_25MHZ,
   input  wire                      reset_from_key,
   input  wire                      kbd_event_ready,
   input  wire  [7:0]               kbd_event_type,
   input  dds_pkg::waveform_t       signal_select,
   input  dds_pkg::modulation_t     modulation_select,
   input  dds_pkg::phase_t          fsk_increment,
   output dds_pkg::held_keys_t      held_keys,
   output logic                     lfsr_bit,
   output dds_pkg::sample_t         modulated_out,
   output dds_pkg::sample_t         selected_out
);
   import dds_pkg::*;

   phase_t phase_inc;    // tuning word back from the keying stage
   logic   data_bit;

   wave_if wave_bus ();

   key_state_tracker u_keys
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .event_ready    (kbd_event_ready),
      .event_type     (key_event_t'(kbd_event_type)),   // raw byte into the code enum
      .held           (held_keys)
   );

   lfsr_bitstream #(.bit_period_cycles(bit_period_cycles)) u_bits
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .data_bit       (data_bit)
   );

   waveform_gen u_wave
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase_inc      (phase_inc),
      .wave           (wave_bus.source)
   );

   modulation_stage u_mod
   (
      .CLK_25MHZ         (CLK_25MHZ),
      .reset_from_key    (reset_from_key),
      .modulation_select (modulation_select),
      .signal_select     (signal_select),
      .fsk_increment     (fsk_increment),
      .data_bit          (data_bit),
      .wave              (wave_bus.sink),
      .phase_inc         (phase_inc),
      .bit_out           (lfsr_bit),
      .modulated         (modulated_out),
      .selected          (selected_out)
   );

endmodule

`default_nettype wire

//--- verilog/key_state_tracker.sv
`timescale 1ns/100ps
`default_nettype none

// turns make/break events into held levels, one bit per key
module key_state_tracker
(
   input  wire                  CLK_25MHZ,
   input  wire                  reset_from_key,
   input  wire                  event_ready,
   input  dds_pkg::key_event_t  event_type,
   output dds_pkg::held_keys_t  held
);
   import dds_pkg::*;

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held <= '0;
      end
      else if (event_ready)
      begin
         case (event_type)
            MAKE_1:      held.key_1 <= 1'b1;
            BREAK_1:     held.key_1 <= 1'b0;
            MAKE_2:      held.key_2 <= 1'b1;
            BREAK_2:     held.key_2 <= 1'b0;
            MAKE_3:      held.key_3 <= 1'b1;
            BREAK_3:     held.key_3 <= 1'b0;
            MAKE_4:      held.key_4 <= 1'b1;
            BREAK_4:     held.key_4 <= 1'b0;
            MAKE_5:      held.key_5 <= 1'b1;
            BREAK_5:     held.key_5 <= 1'b0;
            MAKE_6:      held.key_6 <= 1'b1;
            BREAK_6:     held.key_6 <= 1'b0;
            MAKE_7:      held.key_7 <= 1'b1;
            BREAK_7:     held.key_7 <= 1'b0;
            MAKE_8:      held.key_8 <= 1'b1;
            BREAK_8:     held.key_8 <= 1'b0;
            MAKE_F1:     held.f1    <= 1'b1;
            BREAK_F1:    held.f1    <= 1'b0;
            MAKE_F2:     held.f2    <= 1'b1;
            BREAK_F2:    held.f2    <= 1'b0;
            MAKE_N:      held.n     <= 1'b1;
            BREAK_N:     held.n     <= 1'b0;
            MAKE_M:      held.m     <= 1'b1;
            BREAK_M:     held.m     <= 1'b0;
            MAKE_SPACE:  held.space <= 1'b1;
            BREAK_SPACE: held.space <= 1'b0;
            MAKE_LEFT:   held.left  <= 1'b1;
            BREAK_LEFT:  held.left  <= 1'b0;
            MAKE_RIGHT:  held.right <= 1'b1;
            BREAK_RIGHT: held.right <= 1'b0;
            MAKE_UP:     held.up    <= 1'b1;
            BREAK_UP:    held.up    <= 1'b0;
            MAKE_DOWN:   held.down  <= 1'b1;
            BREAK_DOWN:  held.down  <= 1'b0;
            default:     ;                     // untracked code, keep state
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/lfsr_bitstream.sv
`timescale 1ns/100ps
`default_nettype none
`include "dds_defs.svh"

module lfsr_bitstream
#(
   parameter int bit_period_cycles = `BIT_PERIOD_CYCLES
)
(
   input  wire  CLK_25MHZ,
   input  wire  reset_from_key,
   output logic data_bit
);
   import dds_pkg::*;

   localparam int cnt_w = (bit_period_cycles > 1) ? $clog2(bit_period_cycles) : 1;

   logic [cnt_w-1:0] bit_cnt;
   logic             tick;
   lfsr_t            lfsr_q;

   assign tick = (bit_cnt == cnt_w'(bit_period_cycles - 1));   // last cycle of the period

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key || tick)
         bit_cnt <= '0;
      else
         bit_cnt <= bit_cnt + 1'b1;
   end

   // fibonacci form, taps 0 and 2, period 31
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         lfsr_q <= lfsr_t'(`LFSR_SEED);
      else if (tick)
         lfsr_q <= {lfsr_q[0] ^ lfsr_q[2], lfsr_q[`LFSR_WIDTH-1:1]};
   end

   assign data_bit = lfsr_q[0];

endmodule

`default_nettype wire
